//--- logic/fabric_map_pkg.sv
package fabric_map_pkg;

    localparam int NM     = 2;
    localparam int NS     = 2;
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int NREG   = 8;
    localparam int IDX_W  = $clog2(NREG);
    localparam int MGR_W  = $clog2(NM);
    localparam int TAG_W  = 18;
    localparam int BANK_W = 2;
    localparam int RSVD_W = 7;

    // Map fields of an address from the msb down
    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        logic [BANK_W-1:0] bank;
        logic [RSVD_W-1:0] rsvd;
        logic [IDX_W-1:0]  index;
        logic [1:0]        offset;
    } addr_fields_t;

    typedef union packed {
        logic [ADDR_W-1:0] raw;
        addr_fields_t      f;
    } axil_addr_u;

    // Tag must be clear and the bank must exist
    function automatic logic addr_in_map(axil_addr_u a);
        return (a.f.tag == '0) && (int'(a.f.bank) < NS);
    endfunction

endpackage

//--- logic/axil_pkg.sv
package axil_pkg;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_DECERR = 2'b11;

    // Everything one manager drives
    typedef struct packed {
        logic [fabric_map_pkg::ADDR_W-1:0] aw_addr;
        logic                              aw_valid;
        logic [fabric_map_pkg::DATA_W-1:0] w_data;
        logic [fabric_map_pkg::STRB_W-1:0] w_strb;
        logic                              w_valid;
        logic                              b_ready;
        logic [fabric_map_pkg::ADDR_W-1:0] ar_addr;
        logic                              ar_valid;
        logic                              r_ready;
    } axil_req_t;

    // Everything returned to one manager
    typedef struct packed {
        logic                              aw_ready;
        logic                              w_ready;
        logic [1:0]                        b_resp;
        logic                              b_valid;
        logic                              ar_ready;
        logic [fabric_map_pkg::DATA_W-1:0] r_data;
        logic [1:0]                        r_resp;
        logic                              r_valid;
    } axil_rsp_t;

    // Single-cycle write into one register bank
    typedef struct packed {
        logic                              en;
        logic [fabric_map_pkg::IDX_W-1:0]  index;
        logic [fabric_map_pkg::DATA_W-1:0] data;
        logic [fabric_map_pkg::STRB_W-1:0] strb;
    } bank_wr_t;

endpackage

//--- logic/axil_reg_bank.sv
module axil_reg_bank (
    input  logic                                clock,
    input  logic                                rst_n,
    input  axil_pkg::bank_wr_t                  wr,
    input  logic                                rd_en,
    input  logic [fabric_map_pkg::IDX_W-1:0]    rd_index,
    output logic [fabric_map_pkg::DATA_W-1:0]   rd_data
);
    import fabric_map_pkg::*;

    logic [DATA_W-1:0] regs [NREG];

    // Byte lanes update only where the strobe is set
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int r = 0; r < NREG; r++) begin
                regs[r] <= '0;
            end
        end else if (wr.en) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (wr.strb[b]) begin
                    regs[wr.index][8*b +: 8] <= wr.data[8*b +: 8];
                end
            end
        end
    end

    // Old value wins on a same-cycle write to this register
    always_ff @(posedge clock) begin
        if (rd_en) begin
            rd_data <= regs[rd_index];
        end
    end

endmodule

//--- logic/axil_write_xbar.sv
module axil_write_xbar (
    input  logic                                         clock,
    input  logic                                         rst_n,
    input  axil_pkg::axil_req_t [fabric_map_pkg::NM-1:0] mgr_req,
    output logic [fabric_map_pkg::NM-1:0]                aw_ready,
    output logic [fabric_map_pkg::NM-1:0]                w_ready,
    output logic [fabric_map_pkg::NM-1:0]                b_valid,
    output logic [fabric_map_pkg::NM-1:0][1:0]           b_resp,
    output axil_pkg::bank_wr_t [fabric_map_pkg::NS-1:0]  bank_wr
);
    import axil_pkg::*;
    import fabric_map_pkg::*;

    typedef enum logic {
        WR_IDLE,
        WR_RESP
    } wr_state_e;

    wr_state_e         state;
    logic [MGR_W-1:0]  rr_ptr;
    logic [MGR_W-1:0]  gnt;
    logic [MGR_W-1:0]  pick;
    logic              pick_vld;
    logic              accept;
    logic [NM-1:0]     req;
    axil_addr_u        req_addr;
    logic              in_map;
    logic              wr_pulse;
    logic              wr_err;
    logic [BANK_W-1:0] wr_bank;
    logic [IDX_W-1:0]  wr_index;
    logic [DATA_W-1:0] wr_data;
    logic [STRB_W-1:0] wr_strb;

    // Address and data must arrive together
    always_comb begin
        for (int m = 0; m < NM; m++) begin
            req[m] = mgr_req[m].aw_valid && mgr_req[m].w_valid;
        end
    end

    // Lowest offset from rr_ptr wins
    always_comb begin
        logic [MGR_W-1:0] cand;
        pick     = rr_ptr;
        pick_vld = 1'b0;
        for (int k = NM - 1; k >= 0; k--) begin
            cand = MGR_W'((int'(rr_ptr) + k) % NM);
            if (req[cand]) begin
                pick     = cand;
                pick_vld = 1'b1;
            end
        end
    end

    assign accept   = (state == WR_IDLE) && pick_vld;
    assign req_addr = mgr_req[pick].aw_addr;
    assign in_map   = addr_in_map(req_addr);

    always_comb begin
        for (int m = 0; m < NM; m++) begin
            aw_ready[m] = accept && (pick == MGR_W'(m));
            w_ready[m]  = accept && (pick == MGR_W'(m));
            b_valid[m]  = (state == WR_RESP) && (gnt == MGR_W'(m));
            b_resp[m]   = wr_err ? RESP_DECERR : RESP_OKAY;
        end
        for (int s = 0; s < NS; s++) begin
            bank_wr[s].en    = wr_pulse && (wr_bank == BANK_W'(s));
            bank_wr[s].index = wr_index;
            bank_wr[s].data  = wr_data;
            bank_wr[s].strb  = wr_strb;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state    <= WR_IDLE;
            rr_ptr   <= '0;
            gnt      <= '0;
            wr_pulse <= 1'b0;
            wr_err   <= 1'b0;
            wr_bank  <= '0;
        end else begin
            wr_pulse <= 1'b0;
            case (state)
                WR_IDLE: begin
                    if (accept) begin
                        state    <= WR_RESP;
                        gnt      <= pick;
                        rr_ptr   <= MGR_W'((int'(pick) + 1) % NM);
                        wr_pulse <= in_map;
                        wr_err   <= !in_map;
                        wr_bank  <= req_addr.f.bank;
                    end
                end
                WR_RESP: begin
                    // Hold B until the granted manager takes it
                    if (mgr_req[gnt].b_ready) begin
                        state <= WR_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            wr_index <= req_addr.f.index;
            wr_data  <= mgr_req[pick].w_data;
            wr_strb  <= mgr_req[pick].w_strb;
        end
    end

endmodule

//--- logic/axil_read_xbar.sv
module axil_read_xbar (
    input  logic                                         clock,
    input  logic                                         rst_n,
    input  axil_pkg::axil_req_t [fabric_map_pkg::NM-1:0] mgr_req,
    output logic [fabric_map_pkg::NM-1:0]                ar_ready,
    output logic [fabric_map_pkg::NM-1:0]                r_valid,
    output logic [fabric_map_pkg::NM-1:0][1:0]           r_resp,
    output logic [fabric_map_pkg::NM-1:0][fabric_map_pkg::DATA_W-1:0] r_data,
    output logic [fabric_map_pkg::NS-1:0]                rd_en,
    output logic [fabric_map_pkg::IDX_W-1:0]             rd_index,
    input  logic [fabric_map_pkg::NS-1:0][fabric_map_pkg::DATA_W-1:0] rd_data
);
    import axil_pkg::*;
    import fabric_map_pkg::*;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_BANK,
        RD_RESP
    } rd_state_e;

    rd_state_e         state;
    logic [MGR_W-1:0]  rr_ptr;
    logic [MGR_W-1:0]  gnt;
    logic [MGR_W-1:0]  pick;
    logic              pick_vld;
    logic              accept;
    axil_addr_u        req_addr;
    logic              rd_err;
    logic [BANK_W-1:0] rd_bank;
    logic [DATA_W-1:0] bank_data;

    always_comb begin
        logic [MGR_W-1:0] cand;
        pick     = rr_ptr;
        pick_vld = 1'b0;
        for (int k = NM - 1; k >= 0; k--) begin
            cand = MGR_W'((int'(rr_ptr) + k) % NM);
            if (mgr_req[cand].ar_valid) begin
                pick     = cand;
                pick_vld = 1'b1;
            end
        end
    end

    assign accept   = (state == RD_IDLE) && pick_vld;
    assign req_addr = mgr_req[pick].ar_addr;

    // Bank output holds until the next rd_en, which cannot come before RD_IDLE
    always_comb begin
        bank_data = '0;
        for (int s = 0; s < NS; s++) begin
            if (rd_bank == BANK_W'(s)) begin
                bank_data = rd_data[s];
            end
        end
        for (int s = 0; s < NS; s++) begin
            rd_en[s] = (state == RD_BANK) && !rd_err && (rd_bank == BANK_W'(s));
        end
        for (int m = 0; m < NM; m++) begin
            ar_ready[m] = accept && (pick == MGR_W'(m));
            r_valid[m]  = (state == RD_RESP) && (gnt == MGR_W'(m));
            r_resp[m]   = rd_err ? RESP_DECERR : RESP_OKAY;
            r_data[m]   = (state == RD_RESP && !rd_err) ? bank_data : '0;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state   <= RD_IDLE;
            rr_ptr  <= '0;
            gnt     <= '0;
            rd_err  <= 1'b0;
            rd_bank <= '0;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (accept) begin
                        state   <= RD_BANK;
                        gnt     <= pick;
                        rr_ptr  <= MGR_W'((int'(pick) + 1) % NM);
                        rd_err  <= !addr_in_map(req_addr);
                        rd_bank <= req_addr.f.bank;
                    end
                end
                RD_BANK: state <= RD_RESP;
                RD_RESP: begin
                    if (mgr_req[gnt].r_ready) begin
                        state <= RD_IDLE;
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            rd_index <= req_addr.f.index;
        end
    end

endmodule

//--- logic/axil_fabric_top.sv
module axil_fabric_top (
    input  logic                                         clock,
    input  logic                                         rst_n,
    input  axil_pkg::axil_req_t [fabric_map_pkg::NM-1:0] mgr_req,
    output axil_pkg::axil_rsp_t [fabric_map_pkg::NM-1:0] mgr_rsp
);
    import axil_pkg::*;
    import fabric_map_pkg::*;

    logic [NM-1:0]             aw_ready;
    logic [NM-1:0]             w_ready;
    logic [NM-1:0]             b_valid;
    logic [NM-1:0][1:0]        b_resp;
    logic [NM-1:0]             ar_ready;
    logic [NM-1:0]             r_valid;
    logic [NM-1:0][1:0]        r_resp;
    logic [NM-1:0][DATA_W-1:0] r_data;
    bank_wr_t [NS-1:0]         bank_wr;
    logic [NS-1:0]             rd_en;
    logic [IDX_W-1:0]          rd_index;
    logic [NS-1:0][DATA_W-1:0] rd_data;

    axil_write_xbar u_write_xbar (
        .clock    (clock),
        .rst_n    (rst_n),
        .mgr_req  (mgr_req),
        .aw_ready (aw_ready),
        .w_ready  (w_ready),
        .b_valid  (b_valid),
        .b_resp   (b_resp),
        .bank_wr  (bank_wr)
    );

    axil_read_xbar u_read_xbar (
        .clock    (clock),
        .rst_n    (rst_n),
        .mgr_req  (mgr_req),
        .ar_ready (ar_ready),
        .r_valid  (r_valid),
        .r_resp   (r_resp),
        .r_data   (r_data),
        .rd_en    (rd_en),
        .rd_index (rd_index),
        .rd_data  (rd_data)
    );

    axil_reg_bank bank0 (
        .clock    (clock),
        .rst_n    (rst_n),
        .wr       (bank_wr[0]),
        .rd_en    (rd_en[0]),
        .rd_index (rd_index),
        .rd_data  (rd_data[0])
    );

    axil_reg_bank bank1 (
        .clock    (clock),
        .rst_n    (rst_n),
        .wr       (bank_wr[1]),
        .rd_en    (rd_en[1]),
        .rd_index (rd_index),
        .rd_data  (rd_data[1])
    );

    // Write fields from one crossbar, read fields from the other
    for (genvar m = 0; m < NM; m++) begin : g_rsp
        assign mgr_rsp[m].aw_ready = aw_ready[m];
        assign mgr_rsp[m].w_ready  = w_ready[m];
        assign mgr_rsp[m].b_resp   = b_resp[m];
        assign mgr_rsp[m].b_valid  = b_valid[m];
        assign mgr_rsp[m].ar_ready = ar_ready[m];
        assign mgr_rsp[m].r_data   = r_data[m];
        assign mgr_rsp[m].r_resp   = r_resp[m];
        assign mgr_rsp[m].r_valid  = r_valid[m];
    end

endmodule

//--- verification/axil_fabric_assert.sv
module axil_fabric_assert (
    input logic                                         clock,
    input logic                                         rst_n,
    input axil_pkg::axil_req_t [fabric_map_pkg::NM-1:0] mgr_req,
    input axil_pkg::axil_rsp_t [fabric_map_pkg::NM-1:0] mgr_rsp
);
    import axil_pkg::*;
    import fabric_map_pkg::*;

    int                errors = 0;
    logic              rst_q;
    logic [DATA_W-1:0] shadow [NS][NREG];
    logic [NM-1:0][DATA_W-1:0] exp_rdata;
    logic [NM-1:0][1:0]        exp_rresp;
    logic [NM-1:0][1:0]        exp_bresp;
    logic [NM-1:0] wr_req;
    logic [NM-1:0] aw_rdy;
    logic [NM-1:0] ar_req;
    logic [NM-1:0] ar_rdy;
    logic [NM-1:0] b_vld;
    logic [NM-1:0] r_vld;
    logic          any_hs;
    logic          wr_last;
    logic          rd_last;
    logic          wr_seen;
    logic          rd_seen;

    always_comb begin
        any_hs = 1'b0;
        for (int m = 0; m < NM; m++) begin
            wr_req[m] = mgr_req[m].aw_valid && mgr_req[m].w_valid;
            ar_req[m] = mgr_req[m].ar_valid;
            aw_rdy[m] = mgr_rsp[m].aw_ready;
            ar_rdy[m] = mgr_rsp[m].ar_ready;
            b_vld[m]  = mgr_rsp[m].b_valid;
            r_vld[m]  = mgr_rsp[m].r_valid;
            any_hs = any_hs | aw_rdy[m] | mgr_rsp[m].w_ready | ar_rdy[m] | b_vld[m] | r_vld[m];
        end
    end

    always_ff @(posedge clock) begin
        rst_q <= rst_n;
    end

    // Shadow and expected responses update at each handshake
    always_ff @(posedge clock) begin
        axil_addr_u wa;
        axil_addr_u ra;
        if (!rst_n) begin
            for (int s = 0; s < NS; s++) begin
                for (int r = 0; r < NREG; r++) begin
                    shadow[s][r] <= '0;
                end
            end
            wr_seen <= 1'b0;
            rd_seen <= 1'b0;
        end else begin
            for (int m = 0; m < NM; m++) begin
                if (wr_req[m] && aw_rdy[m]) begin
                    wa      = mgr_req[m].aw_addr;
                    wr_last <= aw_rdy[1];
                    wr_seen <= 1'b1;
                    if (wa.f.tag == '0 && wa.f.bank < NS) begin
                        exp_bresp[m] <= RESP_OKAY;
                        for (int b = 0; b < STRB_W; b++) begin
                            if (mgr_req[m].w_strb[b]) begin
                                shadow[int'(wa.f.bank)][wa.f.index][8*b +: 8] <=
                                    mgr_req[m].w_data[8*b +: 8];
                            end
                        end
                    end else begin
                        exp_bresp[m] <= RESP_DECERR;
                    end
                end
                if (ar_req[m] && ar_rdy[m]) begin
                    ra      = mgr_req[m].ar_addr;
                    rd_last <= ar_rdy[1];
                    rd_seen <= 1'b1;
                    if (ra.f.tag == '0 && ra.f.bank < NS) begin
                        exp_rresp[m] <= RESP_OKAY;
                        exp_rdata[m] <= shadow[int'(ra.f.bank)][ra.f.index];
                    end else begin
                        exp_rresp[m] <= RESP_DECERR;
                        exp_rdata[m] <= '0;
                    end
                end
            end
        end
    end

    a_reset_quiet: assert property (@(posedge clock) (!rst_n || !rst_q) |-> !any_hs)
        else begin
            $error("Ready or valid high during or just after reset");
            errors++;
        end

    a_wr_fair: assert property (@(posedge clock) disable iff (!rst_n)
        (|aw_rdy && &wr_req && wr_seen) |-> !aw_rdy[wr_last])
        else begin
            $error("Write grant did not alternate between managers");
            errors++;
        end

    a_rd_fair: assert property (@(posedge clock) disable iff (!rst_n)
        (|ar_rdy && &ar_req && rd_seen) |-> !ar_rdy[rd_last])
        else begin
            $error("Read grant did not alternate between managers");
            errors++;
        end

    a_wr_stall: assert property (@(posedge clock) disable iff (!rst_n) |b_vld |-> !(|aw_rdy))
        else begin
            $error("Write accepted while a B response was pending");
            errors++;
        end

    a_rd_stall: assert property (@(posedge clock) disable iff (!rst_n) |r_vld |-> !(|ar_rdy))
        else begin
            $error("Read accepted while an R response was pending");
            errors++;
        end

    for (genvar m = 0; m < NM; m++) begin : g_mgr
        a_aw_w: assert property (@(posedge clock) disable iff (!rst_n)
            mgr_rsp[m].aw_ready == mgr_rsp[m].w_ready)
            else begin
                $error("AW ready and W ready differ for mgr %0d", m);
                errors++;
            end
        a_bresp: assert property (@(posedge clock) disable iff (!rst_n)
            mgr_rsp[m].b_valid |-> mgr_rsp[m].b_resp == exp_bresp[m])
            else begin
                $error("Error write_resp mgr %0d expected %h actual %h",
                       m, exp_bresp[m], mgr_rsp[m].b_resp);
                errors++;
            end
        a_rdata: assert property (@(posedge clock) disable iff (!rst_n)
            mgr_rsp[m].r_valid |->
                (mgr_rsp[m].r_resp == exp_rresp[m] && mgr_rsp[m].r_data == exp_rdata[m]))
            else begin
                $error("Error read_data mgr %0d expected %h/%h actual %h/%h", m,
                       exp_rresp[m], exp_rdata[m], mgr_rsp[m].r_resp, mgr_rsp[m].r_data);
                errors++;
            end
        a_b_hold: assert property (@(posedge clock) disable iff (!rst_n)
            (mgr_rsp[m].b_valid && !mgr_req[m].b_ready) |=>
                (mgr_rsp[m].b_valid && $stable(mgr_rsp[m].b_resp)))
            else begin
                $error("B response dropped or changed before b_ready");
                errors++;
            end
        a_r_hold: assert property (@(posedge clock) disable iff (!rst_n)
            (mgr_rsp[m].r_valid && !mgr_req[m].r_ready) |=>
                (mgr_rsp[m].r_valid && $stable(mgr_rsp[m].r_data)
                 && $stable(mgr_rsp[m].r_resp)))
            else begin
                $error("R response dropped or changed before r_ready");
                errors++;
            end
    end

endmodule

bind axil_fabric_top axil_fabric_assert chk (.*);

//--- verification/axil_fabric_tb.sv
module axil_fabric_tb;
    import axil_pkg::*;
    import fabric_map_pkg::*;

    localparam int NTXN        = 100;
    // About 20 cycles worst case per transaction
    localparam int CYCLE_LIMIT = NM * NTXN * 20;

    logic                 clock = 1'b0;
    logic                 rst_n;
    axil_req_t [NM-1:0]   mgr_req;
    axil_rsp_t [NM-1:0]   mgr_rsp;
    logic [31:0]          lfsr = 32'h6a6b_3abe;
    int                   cycles = 0;
    int                   errors;

    axil_fabric_top DUT (
        .clock   (clock),
        .rst_n   (rst_n),
        .mgr_req (mgr_req),
        .mgr_rsp (mgr_rsp)
    );

    always #4 clock = ~clock;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // Roughly 3 in 16 addresses land outside the map
    function automatic logic [ADDR_W-1:0] make_addr();
        axil_addr_u a;
        logic       oom;
        a.raw   = '0;
        oom     = rand_bits(4) < 3;
        a.f.index = IDX_W'(rand_bits(IDX_W));
        a.f.bank  = BANK_W'(rand_bits(1));
        if (oom) begin
            if (rand_bits(1) == 1) begin
                a.f.tag = TAG_W'(1) << rand_bits(4);
            end else begin
                a.f.bank[1] = 1'b1;
            end
        end
        return a.raw;
    endfunction

    task automatic wait_ready_delay();
        int n;
        n = int'(rand_bits(2));
        repeat (n) begin
            @(posedge clock);
            #1;
        end
    endtask

    task automatic write_txn(int m);
        mgr_req[m].aw_addr  = make_addr();
        mgr_req[m].w_data   = rand_bits(32);
        mgr_req[m].w_strb   = STRB_W'(rand_bits(STRB_W));
        mgr_req[m].aw_valid = 1'b1;
        mgr_req[m].w_valid  = 1'b1;
        do @(negedge clock); while (!mgr_rsp[m].aw_ready);
        @(posedge clock);
        #1;
        mgr_req[m].aw_valid = 1'b0;
        mgr_req[m].w_valid  = 1'b0;
        wait_ready_delay();
        mgr_req[m].b_ready = 1'b1;
        do @(negedge clock); while (!mgr_rsp[m].b_valid);
        @(posedge clock);
        #1;
        mgr_req[m].b_ready = 1'b0;
    endtask

    task automatic read_txn(int m);
        mgr_req[m].ar_addr  = make_addr();
        mgr_req[m].ar_valid = 1'b1;
        do @(negedge clock); while (!mgr_rsp[m].ar_ready);
        @(posedge clock);
        #1;
        mgr_req[m].ar_valid = 1'b0;
        wait_ready_delay();
        mgr_req[m].r_ready = 1'b1;
        do @(negedge clock); while (!mgr_rsp[m].r_valid);
        @(posedge clock);
        #1;
        mgr_req[m].r_ready = 1'b0;
    endtask

    task automatic run_manager(int m);
        repeat (NTXN) begin
            if (rand_bits(1) == 1) begin
                write_txn(m);
            end else begin
                read_txn(m);
            end
        end
    endtask

    always @(posedge clock) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: transactions still open after %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        mgr_req = '0;
        rst_n   = 1'b0;
        repeat (10) @(posedge clock);
        #1;
        rst_n = 1'b1;
        // Valid may rise only after the first edge with reset released
        @(posedge clock);
        #1;
        fork
            run_manager(0);
            run_manager(1);
        join
        repeat (4) @(posedge clock);
        errors = DUT.chk.errors;
        $display("Done after %0d cycles, assertion errors: %0d", cycles, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
logic/fabric_map_pkg.sv
logic/axil_pkg.sv
logic/axil_reg_bank.sv
logic/axil_write_xbar.sv
logic/axil_read_xbar.sv
logic/axil_fabric_top.sv
verification/axil_fabric_assert.sv
verification/axil_fabric_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module axil_fabric_tb -f compile.f -o axil_fabric_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/axil_fabric_sim +verilator+error+limit+10000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASSED$" <<< "$out"; then
    exit 0
fi
exit 1
